// File: verilog/op_addr_pkg.sv
package op_addr_pkg;

  localparam int SRC_W = 18;
  localparam int DST_W = 17;

  // field positions of the operand words
  localparam int KIND_HI   = 17;
  localparam int KIND_LO   = 16;
  localparam int WE_BIT    = 16; // destination write enable
  localparam int MODE_HI   = 15;
  localparam int MODE_LO   = 14;
  localparam int CREG_HI   = 15; // resolved words only
  localparam int CREG_LO   = 13;
  localparam int R1_FLAG   = 12;
  localparam int R0_FLAG   = 11;
  localparam int BITPOS_HI = 10;
  localparam int BITPOS_LO = 8;

  // byte addresses of the core's own registers
  localparam logic [7:0] SP_ADDR  = 8'h81;
  localparam logic [7:0] DPL_ADDR = 8'h82;
  localparam logic [7:0] DPH_ADDR = 8'h83;
  localparam logic [7:0] PSW_ADDR = 8'hd0;
  localparam logic [7:0] ACC_ADDR = 8'he0;
  localparam logic [7:0] B_ADDR   = 8'hf0;

  typedef enum logic [1:0] {
    MODE_DIRECT   = 2'd0,
    MODE_INDIRECT = 2'd1,
    MODE_REGISTER = 2'd2,
    MODE_BIT      = 2'd3
  } addr_mode_e;

  typedef enum logic [2:0] {
    CREG_NONE = 3'd0,
    CREG_DPL  = 3'd1,
    CREG_DPH  = 3'd2,
    CREG_SP   = 3'd3,
    CREG_B    = 3'd4,
    CREG_ACC  = 3'd5,
    CREG_PSW  = 3'd6
  } core_reg_e;

  function automatic logic [7:0] effective_addr(addr_mode_e mode, logic [7:0] op_byte,
                                                logic [1:0] bank, logic [7:0] r0,
                                                logic [7:0] r1);
    case (mode)
      MODE_DIRECT:   effective_addr = op_byte;
      MODE_INDIRECT: effective_addr = op_byte[0] ? r1 : r0;
      MODE_REGISTER: effective_addr = {3'b000, bank, op_byte[2:0]};
      // bit space: sfr bits map onto 8-aligned bytes, the rest into 20h..2fh
      default:       effective_addr = op_byte[7] ? {op_byte[7:3], 3'b000}
                                                 : {3'b001, op_byte[7:3]};
    endcase
  endfunction

  function automatic core_reg_e core_reg_of(logic [7:0] addr);
    case (addr)
      DPL_ADDR: core_reg_of = CREG_DPL;
      DPH_ADDR: core_reg_of = CREG_DPH;
      SP_ADDR:  core_reg_of = CREG_SP;
      B_ADDR:   core_reg_of = CREG_B;
      ACC_ADDR: core_reg_of = CREG_ACC;
      PSW_ADDR: core_reg_of = CREG_PSW;
      default:  core_reg_of = CREG_NONE;
    endcase
  endfunction

endpackage

// File: verilog/mem_space_pkg.sv
package mem_space_pkg;

  // memory space a source operand reads from, held in the top two bits
  typedef enum logic [1:0] {
    KIND_NONE  = 2'd0, // no operand
    KIND_IRAM  = 2'd1, // internal ram or sfr, 8-bit address
    KIND_CODE  = 2'd2, // code rom, 16-bit address
    KIND_XDATA = 2'd3  // external ram, 16-bit address
  } src_kind_e;

endpackage

// File: verilog/src_addr_resolve.sv
`timescale 1ns/1ps

module src_addr_resolve (
  input  logic                           rst,
  input  logic [op_addr_pkg::SRC_W-1:0]  source0,
  input  logic [1:0]                     bank,
  input  logic [7:0]                     r0,
  input  logic [7:0]                     r1,
  input  logic                           stall_alu,
  input  logic                           nop_dec,
  output logic [op_addr_pkg::SRC_W-1:0]  source1,
  output logic [7:0]                     addr8,
  output logic [15:0]                    addr16,
  output logic                           rom_read,
  output logic                           i_ram_read,
  output logic                           e_ram_read
);
  import op_addr_pkg::*;
  import mem_space_pkg::*;

  src_kind_e  kind;
  addr_mode_e mode;
  logic [7:0] eff_addr;
  core_reg_e  creg;
  logic [2:0] bit_pos;

  assign kind = src_kind_e'(source0[KIND_HI:KIND_LO]);
  assign mode = addr_mode_e'(source0[MODE_HI:MODE_LO]);

  // in bit mode eff_addr is already the byte holding the bit
  assign eff_addr = effective_addr(mode, source0[7:0], bank, r0, r1);
  assign creg     = core_reg_of(eff_addr);
  assign bit_pos  = (mode == MODE_BIT) ? source0[2:0] : 3'b000;

  always_comb begin
    if (kind == KIND_IRAM) begin
      source1 = {kind, creg, 2'b00, bit_pos, eff_addr};
    end else begin
      source1 = source0; // long operands pass untouched
    end
  end

  assign addr8  = source1[7:0];
  assign addr16 = source1[15:0];

  always_comb begin
    rom_read   = 1'b0;
    i_ram_read = 1'b0;
    e_ram_read = 1'b0;
    if (!(rst || stall_alu || nop_dec)) begin
      case (kind)
        KIND_CODE:  rom_read   = 1'b1;
        KIND_XDATA: e_ram_read = 1'b1;
        KIND_IRAM:  i_ram_read = (creg == CREG_NONE); // core regs are read inside the core
        default:    ;
      endcase
    end
  end

endmodule

// File: verilog/dst_addr_resolve.sv
`timescale 1ns/1ps

module dst_addr_resolve (
  input  logic [op_addr_pkg::DST_W-1:0]  dest0,
  input  logic [1:0]                     bank,
  input  logic [7:0]                     r0,
  input  logic [7:0]                     r1,
  output logic [op_addr_pkg::DST_W-1:0]  dest1
);
  import op_addr_pkg::*;

  addr_mode_e mode;
  logic [7:0] eff_addr;
  core_reg_e  creg;
  logic [7:0] r0_addr;
  logic [7:0] r1_addr;
  logic       wr_r0;
  logic       wr_r1;

  assign mode     = addr_mode_e'(dest0[MODE_HI:MODE_LO]);
  assign eff_addr = effective_addr(mode, dest0[7:0], bank, r0, r1);
  assign creg     = core_reg_of(eff_addr);

  // R0 and R1 of the current bank, used as pointers by later operands
  assign r0_addr = {3'b000, bank, 3'b000};
  assign r1_addr = {3'b000, bank, 3'b001};

  assign wr_r0 = (creg == CREG_NONE) && (eff_addr == r0_addr);
  assign wr_r1 = (creg == CREG_NONE) && (eff_addr == r1_addr);

  always_comb begin
    dest1 = '0;
    if (dest0[WE_BIT]) begin
      dest1[WE_BIT]          = 1'b1;
      dest1[CREG_HI:CREG_LO] = creg;
      dest1[R1_FLAG]         = wr_r1;
      dest1[R0_FLAG]         = wr_r0;
      dest1[7:0]             = eff_addr;
    end
  end

endmodule

// File: verilog/hazard_detect.sv
`timescale 1ns/1ps

module hazard_detect #(
  parameter int PIPE_DEPTH = 3
) (
  input  logic [op_addr_pkg::SRC_W-1:0]                  source0,
  input  logic [op_addr_pkg::SRC_W-1:0]                  source1,
  input  logic [op_addr_pkg::DST_W-1:0]                  dest0,
  input  logic [op_addr_pkg::DST_W-1:0]                  dest1,
  input  logic [PIPE_DEPTH-1:0][op_addr_pkg::DST_W-1:0]  pend_dest,
  input  logic [PIPE_DEPTH-1:0]                          pend_nop,
  input  logic                                           r0_valid,
  input  logic                                           r1_valid,
  input  logic                                           r_invalid,
  input  logic                                           stall_dec_addr,
  output logic                                           stall
);
  import op_addr_pkg::*;
  import mem_space_pkg::*;

  logic [PIPE_DEPTH-1:0] addr_hit; // pending write to source1's address
  logic [PIPE_DEPTH-1:0] psw_wr;   // pending psw write that may switch bank
  logic [PIPE_DEPTH-1:0] r0_wr;
  logic [PIPE_DEPTH-1:0] r1_wr;
  addr_mode_e            src_mode;
  addr_mode_e            dst_mode;
  logic                  src_ptr_bad;
  logic                  dst_ptr_bad;
  logic                  stall_s;
  logic                  stall_d;

  always_comb begin
    for (int i = 0; i < PIPE_DEPTH; i++) begin
      // bubbles and non-writing stages never count
      addr_hit[i] = !pend_nop[i] && pend_dest[i][WE_BIT] && (pend_dest[i][7:0] == source1[7:0]);
      psw_wr[i]   = !pend_nop[i] && pend_dest[i][WE_BIT] && (pend_dest[i][7:0] == PSW_ADDR);
      r0_wr[i]    = !pend_nop[i] && pend_dest[i][WE_BIT] && pend_dest[i][R0_FLAG];
      r1_wr[i]    = !pend_nop[i] && pend_dest[i][WE_BIT] && pend_dest[i][R1_FLAG];
    end
  end

  assign src_mode = addr_mode_e'(source0[MODE_HI:MODE_LO]);
  assign dst_mode = addr_mode_e'(dest0[MODE_HI:MODE_LO]);

  // pointer pending, not valid yet, or globally invalid
  assign src_ptr_bad = source0[0] ? (|r1_wr || !r1_valid) : (|r0_wr || !r0_valid);
  assign dst_ptr_bad = dest0[0]   ? (|r1_wr || !r1_valid) : (|r0_wr || !r0_valid);

  always_comb begin
    stall_s = 1'b0;
    if (src_kind_e'(source0[KIND_HI:KIND_LO]) == KIND_IRAM) begin
      stall_s = |addr_hit;
      if (src_mode == MODE_INDIRECT) stall_s = stall_s || src_ptr_bad || r_invalid;
      if (src_mode == MODE_INDIRECT || src_mode == MODE_REGISTER) stall_s = stall_s || |psw_wr;
    end
  end

  always_comb begin
    stall_d = 1'b0;
    if (dest1[WE_BIT]) begin // enable carried over from dest0
      if (dst_mode == MODE_INDIRECT) stall_d = dst_ptr_bad || r_invalid;
      if (dst_mode == MODE_INDIRECT || dst_mode == MODE_REGISTER) stall_d = stall_d || |psw_wr;
    end
  end

  assign stall = (stall_s || stall_d) && !stall_dec_addr;

endmodule

// File: verilog/dest_pipeline.sv
`timescale 1ns/1ps

module dest_pipeline #(
  parameter int PIPE_DEPTH = 3
) (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic [op_addr_pkg::DST_W-1:0]                  dest1,
  input  logic                                           nop_dec,
  input  logic                                           stall,
  input  logic                                           stall_alu,
  output logic [PIPE_DEPTH-1:0][op_addr_pkg::DST_W-1:0]  pend_dest,
  output logic [PIPE_DEPTH-1:0]                          pend_nop,
  output logic [op_addr_pkg::DST_W-1:0]                  wb_dest,
  output logic                                           wb_valid
);
  import op_addr_pkg::*;

  // stage 0 is the oldest, PIPE_DEPTH-1 takes the new destination
  always_ff @(posedge clk) begin
    if (rst) begin
      pend_dest <= '0;
      pend_nop  <= '1; // flush to bubbles
    end else if (!stall_alu) begin
      for (int i = 0; i < PIPE_DEPTH - 1; i++) begin
        pend_dest[i] <= pend_dest[i+1];
        pend_nop[i]  <= pend_nop[i+1];
      end
      pend_dest[PIPE_DEPTH-1] <= dest1;
      pend_nop[PIPE_DEPTH-1]  <= nop_dec || stall; // stalled op does not advance
    end
  end

  assign wb_dest  = pend_dest[0];
  assign wb_valid = !pend_nop[0] && pend_dest[0][WE_BIT];

  a_frozen: assert property (@(posedge clk) disable iff (rst)
    stall_alu |=> ($stable(pend_dest) && $stable(pend_nop)))
    else $error("destination stages moved while stall_alu high");

endmodule

// File: verilog/op_address_top.sv
`timescale 1ns/1ps

module op_address_top #(
  parameter int PIPE_DEPTH = 3
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [op_addr_pkg::SRC_W-1:0]  source0,
  input  logic [op_addr_pkg::DST_W-1:0]  dest0,
  input  logic [1:0]                     bank,
  input  logic [7:0]                     r0,
  input  logic [7:0]                     r1,
  input  logic                           r0_valid,
  input  logic                           r1_valid,
  input  logic                           r_invalid,
  input  logic                           stall_alu,
  input  logic                           nop_dec,
  input  logic                           stall_dec_addr,
  output logic [op_addr_pkg::SRC_W-1:0]  source1,
  output logic [7:0]                     addr8,
  output logic [15:0]                    addr16,
  output logic                           rom_read,
  output logic                           i_ram_read,
  output logic                           e_ram_read,
  output logic                           stall,
  output logic [op_addr_pkg::DST_W-1:0]  wb_dest,
  output logic                           wb_valid
);
  import op_addr_pkg::*;

  logic [DST_W-1:0]                  dest1;
  logic [PIPE_DEPTH-1:0][DST_W-1:0]  pend_dest;
  logic [PIPE_DEPTH-1:0]             pend_nop;

  src_addr_resolve src_i (
    .rst(rst), .source0(source0), .bank(bank), .r0(r0), .r1(r1),
    .stall_alu(stall_alu), .nop_dec(nop_dec), .source1(source1),
    .addr8(addr8), .addr16(addr16), .rom_read(rom_read),
    .i_ram_read(i_ram_read), .e_ram_read(e_ram_read)
  );

  dst_addr_resolve dst_i (
    .dest0(dest0), .bank(bank), .r0(r0), .r1(r1), .dest1(dest1)
  );

  hazard_detect #(.PIPE_DEPTH(PIPE_DEPTH)) haz_i (
    .source0(source0), .source1(source1), .dest0(dest0), .dest1(dest1),
    .pend_dest(pend_dest), .pend_nop(pend_nop), .r0_valid(r0_valid),
    .r1_valid(r1_valid), .r_invalid(r_invalid),
    .stall_dec_addr(stall_dec_addr), .stall(stall)
  );

  // destinations in flight toward write-back
  dest_pipeline #(.PIPE_DEPTH(PIPE_DEPTH)) pipe_i (
    .clk(clk), .rst(rst), .dest1(dest1), .nop_dec(nop_dec), .stall(stall),
    .stall_alu(stall_alu), .pend_dest(pend_dest), .pend_nop(pend_nop),
    .wb_dest(wb_dest), .wb_valid(wb_valid)
  );

endmodule

// File: verif/op_address_checker.sv
`timescale 1ns/1ps

module op_address_checker #(
  parameter int PIPE_DEPTH = 3
) (
  input  logic                           clk,
  input  logic                           rst,
  input  int                             test_id,
  input  logic [op_addr_pkg::SRC_W-1:0]  source0,
  input  logic [op_addr_pkg::DST_W-1:0]  dest0,
  input  logic [1:0]                     bank,
  input  logic [7:0]                     r0,
  input  logic [7:0]                     r1,
  input  logic                           r0_valid,
  input  logic                           r1_valid,
  input  logic                           r_invalid,
  input  logic                           stall_alu,
  input  logic                           nop_dec,
  input  logic                           stall_dec_addr,
  input  logic [op_addr_pkg::SRC_W-1:0]  source1,
  input  logic [7:0]                     addr8,
  input  logic [15:0]                    addr16,
  input  logic                           rom_read,
  input  logic                           i_ram_read,
  input  logic                           e_ram_read,
  input  logic                           stall,
  input  logic [op_addr_pkg::DST_W-1:0]  wb_dest,
  input  logic                           wb_valid,
  output int                             errors,
  output int                             checks
);
  import op_addr_pkg::*;
  import mem_space_pkg::*;

  logic [DST_W-1:0] model_dest [PIPE_DEPTH]; // index 0 is the oldest stage
  logic             model_nop  [PIPE_DEPTH];
  logic [SRC_W-1:0] exp_src;
  logic [DST_W-1:0] exp_dst;
  logic             exp_stall;
  int               n_err = 0;
  int               n_chk = 0;

  assign errors = n_err;
  assign checks = n_chk;

  function automatic string test_name(int id);
    case (id)
      1:       return "iram_sources";
      2:       return "long_sources";
      3:       return "indirect";
      4:       return "pending_hazard";
      5:       return "pipeline_flow";
      6:       return "reset_flush";
      7:       return "random";
      default: return "reset";
    endcase
  endfunction

  function automatic logic [7:0] ref_addr(logic [1:0] mode, logic [7:0] b);
    case (mode)
      MODE_DIRECT:   return b;
      MODE_INDIRECT: return b[0] ? r1 : r0;
      MODE_REGISTER: return {3'b000, bank, b[2:0]};
      default:       return b[7] ? {b[7:3], 3'b000} : 8'h20 + {3'b000, b[7:3]};
    endcase
  endfunction

  function automatic logic [2:0] ref_creg(logic [7:0] a);
    case (a)
      8'h82:   return CREG_DPL;
      8'h83:   return CREG_DPH;
      8'h81:   return CREG_SP;
      8'hf0:   return CREG_B;
      8'he0:   return CREG_ACC;
      8'hd0:   return CREG_PSW;
      default: return CREG_NONE;
    endcase
  endfunction

  function automatic logic [SRC_W-1:0] ref_source1(logic [SRC_W-1:0] s);
    logic [7:0] a;
    a = ref_addr(s[15:14], s[7:0]);
    if (s[17:16] != KIND_IRAM) return s; // long operands unchanged
    return {s[17:16], ref_creg(a), 2'b00, (s[15:14] == MODE_BIT) ? s[2:0] : 3'b000, a};
  endfunction

  function automatic logic [DST_W-1:0] ref_dest1(logic [DST_W-1:0] d);
    logic [7:0] a;
    logic [2:0] c;
    a = ref_addr(d[15:14], d[7:0]);
    c = ref_creg(a);
    if (!d[16]) return '0;
    return {1'b1, c, (c == CREG_NONE) && (a == {3'b000, bank, 3'b001}),
            (c == CREG_NONE) && (a == {3'b000, bank, 3'b000}), 3'b000, a};
  endfunction

  // rom, iram, xram read strobes
  function automatic logic [2:0] ref_strobes(logic [SRC_W-1:0] s, logic [SRC_W-1:0] s1);
    if (rst || stall_alu || nop_dec) return 3'b000;
    case (s[17:16])
      KIND_CODE:  return 3'b100;
      KIND_XDATA: return 3'b001;
      KIND_IRAM:  return {1'b0, s1[15:13] == CREG_NONE, 1'b0};
      default:    return 3'b000;
    endcase
  endfunction

  function automatic logic ref_stall(logic [SRC_W-1:0] s, logic [SRC_W-1:0] s1,
                                     logic [DST_W-1:0] d);
    logic hit;
    logic psw;
    logic w0;
    logic w1;
    logic st_s;
    logic st_d;
    hit = 1'b0;
    psw = 1'b0;
    w0 = 1'b0;
    w1 = 1'b0;
    for (int i = 0; i < PIPE_DEPTH; i++) begin
      if (!model_nop[i] && model_dest[i][16]) begin // only real pending writes
        hit = hit || (model_dest[i][7:0] == s1[7:0]);
        psw = psw || (model_dest[i][7:0] == 8'hd0);
        w0 = w0 || model_dest[i][11];
        w1 = w1 || model_dest[i][12];
      end
    end
    st_s = (s[17:16] == KIND_IRAM) && (hit
           || (s[15:14] == MODE_INDIRECT
               && ((s[0] ? (w1 || !r1_valid) : (w0 || !r0_valid)) || r_invalid))
           || ((s[15:14] == MODE_INDIRECT || s[15:14] == MODE_REGISTER) && psw));
    st_d = d[16] && ((d[15:14] == MODE_INDIRECT
                      && ((d[0] ? (w1 || !r1_valid) : (w0 || !r0_valid)) || r_invalid))
           || ((d[15:14] == MODE_INDIRECT || d[15:14] == MODE_REGISTER) && psw));
    return (st_s || st_d) && !stall_dec_addr;
  endfunction

  task automatic compare(string what, logic [31:0] exp, logic [31:0] act);
    n_chk++;
    if (exp !== act) begin
      n_err++;
      $display("ERROR %s: %s expected %h actual %h", test_name(test_id), what, exp, act);
    end
  endtask

  always @(posedge clk) begin
    exp_src   = ref_source1(source0);
    exp_dst   = ref_dest1(dest0);
    exp_stall = ref_stall(source0, exp_src, dest0);
    compare("source1", 32'(exp_src), 32'(source1));
    compare("addr8", 32'(exp_src[7:0]), 32'(addr8));
    compare("addr16", 32'(exp_src[15:0]), 32'(addr16));
    compare("strobes", 32'(ref_strobes(source0, exp_src)),
            32'({rom_read, i_ram_read, e_ram_read}));
    if (!rst) begin
      compare("stall", 32'(exp_stall), 32'(stall));
      compare("wb_dest", 32'(model_dest[0]), 32'(wb_dest));
      compare("wb_valid", 32'(!model_nop[0] && model_dest[0][16]), 32'(wb_valid));
    end
    if (rst) begin
      for (int i = 0; i < PIPE_DEPTH; i++) begin
        model_dest[i] = '0;
        model_nop[i]  = 1'b1;
      end
    end else if (!stall_alu) begin
      for (int i = 0; i < PIPE_DEPTH - 1; i++) begin
        model_dest[i] = model_dest[i+1];
        model_nop[i]  = model_nop[i+1];
      end
      model_dest[PIPE_DEPTH-1] = exp_dst;
      model_nop[PIPE_DEPTH-1]  = nop_dec || exp_stall;
    end
  end

endmodule

// File: verif/op_address_tb.sv
`timescale 1ns/1ps

module op_address_tb;
  import op_addr_pkg::*;
  import mem_space_pkg::*;

  localparam int PIPE_DEPTH = 3;
  localparam int N_IRAM = 36;
  localparam int N_LONG = 16;
  localparam int N_IND  = 32;
  localparam int N_HAZ  = 14;
  localparam int N_FLOW = 32;
  localparam int N_RST  = 12;
  localparam int N_RAND = 240;
  localparam int TOTAL_CYCLES = 3 + N_IRAM + N_LONG + N_IND + N_HAZ + N_FLOW + N_RST + N_RAND + 2;

  logic             clk = 1'b0;
  logic             rst;
  logic [SRC_W-1:0] source0;
  logic [DST_W-1:0] dest0;
  logic [1:0]       bank;
  logic [7:0]       r0;
  logic [7:0]       r1;
  logic             r0_valid;
  logic             r1_valid;
  logic             r_invalid;
  logic             stall_alu;
  logic             nop_dec;
  logic             stall_dec_addr;
  logic [SRC_W-1:0] source1;
  logic [7:0]       addr8;
  logic [15:0]      addr16;
  logic             rom_read;
  logic             i_ram_read;
  logic             e_ram_read;
  logic             stall;
  logic [DST_W-1:0] wb_dest;
  logic             wb_valid;
  int               test_id;
  int               errors;
  int               checks;
  logic [31:0]      lfsr = 32'hf3362d92;
  logic [1:0]       mode;
  logic [7:0]       b;

  op_address_top #(.PIPE_DEPTH(PIPE_DEPTH)) dut_i (.*);

  op_address_checker #(.PIPE_DEPTH(PIPE_DEPTH)) checker_i (.*);

  always #5 clk = ~clk;

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic chance(int n); // true with probability 1 in 2**n
    return take_bits(n) == 32'd0;
  endfunction

  function automatic logic [SRC_W-1:0] src_word(logic [1:0] kind, logic [1:0] m, logic [7:0] v);
    return {kind, m, 6'b000000, v};
  endfunction

  function automatic logic [SRC_W-1:0] long_word(logic [1:0] kind, logic [15:0] a);
    return {kind, a};
  endfunction

  function automatic logic [DST_W-1:0] dst_word(logic we, logic [1:0] m, logic [7:0] v);
    return {we, m, 6'b000000, v};
  endfunction

  function automatic logic [7:0] core_addr(int k);
    case (k)
      0:       return 8'h82;
      1:       return 8'h83;
      2:       return 8'h81;
      3:       return 8'hf0;
      4:       return 8'he0;
      default: return 8'hd0;
    endcase
  endfunction

  task automatic quiet_inputs();
    source0 = '0;
    dest0 = '0;
    bank = 2'd0;
    r0 = 8'h00;
    r1 = 8'h00;
    r0_valid = 1'b1;
    r1_valid = 1'b1;
    r_invalid = 1'b0;
    stall_alu = 1'b0;
    nop_dec = 1'b0;
    stall_dec_addr = 1'b0;
  endtask

  initial begin
    rst = 1'b1;
    test_id = 0;
    quiet_inputs();
    source0 = long_word(KIND_CODE, 16'h00ff); // strobe must stay low under reset
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    quiet_inputs();

    test_id = 1;
    for (int i = 0; i < N_IRAM; i++) begin
      @(negedge clk);
      quiet_inputs();
      bank = 2'(take_bits(2));
      mode = (i % 3 == 0) ? MODE_DIRECT : (i % 3 == 1) ? MODE_REGISTER : MODE_BIT;
      b = (i % 6 == 0) ? core_addr(i / 6) : 8'(take_bits(8));
      source0 = src_word(KIND_IRAM, mode, b);
    end

    test_id = 2;
    for (int i = 0; i < N_LONG; i++) begin
      @(negedge clk);
      quiet_inputs();
      source0 = long_word(take_bits(1) != 0 ? KIND_CODE : KIND_XDATA, 16'(take_bits(16)));
      nop_dec = chance(2);
      stall_alu = chance(2);
    end

    test_id = 3;
    for (int i = 0; i < N_IND; i++) begin
      @(negedge clk);
      quiet_inputs();
      bank = 2'(take_bits(2));
      r0 = 8'(take_bits(8));
      r1 = 8'(take_bits(8));
      r0_valid = !chance(2);
      r1_valid = !chance(2);
      r_invalid = chance(3);
      stall_dec_addr = chance(2);
      source0 = src_word(KIND_IRAM, MODE_INDIRECT, 8'(take_bits(1)));
      dest0 = dst_word(1'(take_bits(1)), MODE_INDIRECT, 8'(take_bits(1)));
    end

    test_id = 4;
    @(negedge clk);
    quiet_inputs();
    dest0 = dst_word(1'b1, MODE_DIRECT, 8'h30);
    @(negedge clk);
    quiet_inputs();
    source0 = src_word(KIND_IRAM, MODE_DIRECT, 8'h30); // held while the write is pending
    repeat (4) @(negedge clk);
    quiet_inputs();
    dest0 = dst_word(1'b1, MODE_DIRECT, PSW_ADDR);
    @(negedge clk);
    quiet_inputs();
    source0 = src_word(KIND_IRAM, MODE_REGISTER, 8'h03);
    repeat (3) @(negedge clk);
    quiet_inputs();
    dest0 = dst_word(1'b1, MODE_DIRECT, PSW_ADDR);
    @(negedge clk);
    quiet_inputs();
    dest0 = dst_word(1'b1, MODE_REGISTER, 8'h05);
    repeat (3) @(negedge clk);

    test_id = 5;
    for (int i = 0; i < N_FLOW; i++) begin
      quiet_inputs();
      dest0 = dst_word(1'b1, MODE_DIRECT, 8'(take_bits(8)));
      source0 = src_word(KIND_IRAM, MODE_INDIRECT, 8'h00);
      r0 = 8'h7f;
      r0_valid = !chance(2); // invalid pointer stalls and makes a bubble
      nop_dec = chance(2);
      stall_alu = chance(2);
      @(negedge clk);
    end

    test_id = 6;
    quiet_inputs();
    dest0 = dst_word(1'b1, MODE_DIRECT, 8'h40);
    repeat (3) @(negedge clk);
    rst = 1'b1;
    quiet_inputs();
    source0 = long_word(KIND_CODE, 16'h1234);
    repeat (3) @(negedge clk);
    rst = 1'b0;
    source0 = src_word(KIND_IRAM, MODE_DIRECT, 8'h40); // flushed write must not stall
    repeat (6) @(negedge clk);

    test_id = 7;
    for (int i = 0; i < N_RAND; i++) begin
      source0 = {2'(take_bits(2)), 2'(take_bits(2)), 6'(take_bits(6)), 3'b000, 5'(take_bits(5))};
      dest0 = {1'(take_bits(1)), 2'(take_bits(2)), 6'b000000, 3'b000, 5'(take_bits(5))};
      bank = 2'(take_bits(2));
      r0 = {3'b000, 5'(take_bits(5))};
      r1 = {3'b000, 5'(take_bits(5))};
      r0_valid = !chance(2);
      r1_valid = !chance(2);
      r_invalid = chance(3);
      stall_alu = chance(3);
      nop_dec = chance(3);
      stall_dec_addr = chance(3);
      @(negedge clk);
    end

    quiet_inputs();
    @(posedge clk);
    #1;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(2 * TOTAL_CYCLES * 10);
    $display("timeout, the stimulus did not reach its end in time");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: op_address_top.f
verilog/op_addr_pkg.sv
verilog/mem_space_pkg.sv
verilog/src_addr_resolve.sv
verilog/dst_addr_resolve.sv
verilog/hazard_detect.sv
verilog/dest_pipeline.sv
verilog/op_address_top.sv
verif/op_address_checker.sv
verif/op_address_tb.sv

// File: Makefile
# Verilator build and run of the operand address stage testbench

VERILATOR ?= verilator
TOP       ?= op_address_tb
FILELIST  ?= op_address_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
